// File: riscv_ex_pkg.sv
package riscv_ex_pkg;

  // operand and result width
  localparam int XLEN = 32;

  // RV32I major opcodes, instruction bits [6:0]
  typedef enum logic [6:0] {
    // load upper immediate
    LUI    = 7'b0110111,
    // add upper immediate to pc
    AUIPC  = 7'b0010111,
    // jump and link
    JAL    = 7'b1101111,
    // jump and link register
    JALR   = 7'b1100111,
    // conditional branch, compared by subtraction
    BRANCH = 7'b1100011,
    // memory load
    LOAD   = 7'b0000011,
    // memory store
    STORE  = 7'b0100011,
    // register-immediate arithmetic
    OP_IMM = 7'b0010011,
    // register-register arithmetic
    OP     = 7'b0110011,
    // memory ordering
    FENCE  = 7'b0001111,
    // ecall, ebreak and csr access
    SYS    = 7'b1110011
  } rv_opcode_e;

  // ALU operations, encoded as {inst[30], funct3}
  typedef enum logic [3:0] {
    ALU_ADD  = 4'b0000,
    ALU_SLL  = 4'b0001,
    ALU_SLT  = 4'b0010,
    ALU_SLTU = 4'b0011,
    ALU_XOR  = 4'b0100,
    ALU_SRL  = 4'b0101,
    ALU_OR   = 4'b0110,
    ALU_AND  = 4'b0111,
    ALU_SUB  = 4'b1000,
    ALU_SRA  = 4'b1101,
    // no ALU work, result is zero
    ALU_NONE = 4'b1111
  } alu_op_e;

endpackage

// File: riscv_ex_decode.sv
`timescale 1ns/1ps

module riscv_ex_decode
  import riscv_ex_pkg::*;
(
  input  logic             clk,
  input  logic             arst_n,
  input  logic             in_valid,
  input  logic [31:0]      in_inst,
  input  logic [XLEN-1:0]  in_a,
  input  logic [XLEN-1:0]  in_b,
  output logic             push,
  output alu_op_e          push_op,
  output logic [XLEN-1:0]  push_a,
  output logic [XLEN-1:0]  push_b
);

  rv_opcode_e  opcode;
  logic [2:0]  funct3;
  logic        bit30;
  alu_op_e     dec_op;

  assign opcode = rv_opcode_e'(in_inst[6:0]);
  assign funct3 = in_inst[14:12];
  assign bit30  = in_inst[30];

  // opcode field to ALU operation
  always_comb begin
    case (opcode)
      OP: begin
        dec_op = alu_op_e'({bit30, funct3});
      end
      OP_IMM: begin
        // immediates carry no sub, but srai keeps bit 30
        if (funct3 == 3'b101) begin
          dec_op = alu_op_e'({bit30, funct3});
        end else begin
          dec_op = alu_op_e'({1'b0, funct3});
        end
      end
      // branch compares by a - b, zero flag tells equality
      BRANCH: begin
        dec_op = ALU_SUB;
      end
      default: begin
        dec_op = ALU_NONE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      push <= 1'b0;
    end else begin
      push <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid) begin
      push_op <= dec_op;
      push_a  <= in_a;
      push_b  <= in_b;
    end
  end

endmodule

// File: riscv_ex_queue.sv
`timescale 1ns/1ps

module riscv_ex_queue
  import riscv_ex_pkg::*;
#(
  parameter int QUEUE_DEPTH = 4
) (
  input  logic             clk,
  input  logic             arst_n,
  input  logic             push,
  input  alu_op_e          push_op,
  input  logic [XLEN-1:0]  push_a,
  input  logic [XLEN-1:0]  push_b,
  input  logic             pop,
  output logic             q_valid,
  output alu_op_e          q_op,
  output logic [XLEN-1:0]  q_a,
  output logic [XLEN-1:0]  q_b
);

  localparam int PTR_W = $clog2(QUEUE_DEPTH);
  localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

  alu_op_e          op_mem [QUEUE_DEPTH];
  logic [XLEN-1:0]  a_mem  [QUEUE_DEPTH];
  logic [XLEN-1:0]  b_mem  [QUEUE_DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;

  // wraps at QUEUE_DEPTH, which need not be a power of two
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(QUEUE_DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      op_mem[wr_ptr] <= push_op;
      a_mem[wr_ptr]  <= push_a;
      b_mem[wr_ptr]  <= push_b;
    end
  end

  // head entry shown without a register stage
  assign q_valid = (count != '0);
  assign q_op    = op_mem[rd_ptr];
  assign q_a     = a_mem[rd_ptr];
  assign q_b     = b_mem[rd_ptr];

endmodule

// File: riscv_ex_alu.sv
`timescale 1ns/1ps

module riscv_ex_alu
  import riscv_ex_pkg::*;
#(
  parameter int OUT_CREDITS = 2
) (
  input  logic             clk,
  input  logic             arst_n,
  input  logic             q_valid,
  input  alu_op_e          q_op,
  input  logic [XLEN-1:0]  q_a,
  input  logic [XLEN-1:0]  q_b,
  output logic             pop,
  input  logic             out_credit,
  output logic             out_valid,
  output logic [XLEN-1:0]  out_result,
  output logic             out_zero
);

  localparam int CRED_W = $clog2(OUT_CREDITS + 1);

  logic [CRED_W-1:0] credit;
  logic [XLEN-1:0]   result;
  logic [4:0]        shamt;
  logic              lt_s;
  logic              lt_u;

  // take the head entry only while the sink can accept a result
  assign pop = q_valid && (credit != '0);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      credit <= CRED_W'(OUT_CREDITS);
    end else begin
      case ({pop, out_credit})
        2'b10:   credit <= credit - 1'b1;
        2'b01:   credit <= credit + 1'b1;
        default: credit <= credit;
      endcase
    end
  end

  assign shamt = q_b[4:0];
  assign lt_s  = $signed(q_a) < $signed(q_b);
  assign lt_u  = q_a < q_b;

  always_comb begin
    case (q_op)
      ALU_ADD:  result = q_a + q_b;
      ALU_SUB:  result = q_a - q_b;
      ALU_SLL:  result = q_a << shamt;
      ALU_SRL:  result = q_a >> shamt;
      ALU_SRA:  result = $unsigned($signed(q_a) >>> shamt);
      ALU_SLT:  result = {{(XLEN-1){1'b0}}, lt_s};
      ALU_SLTU: result = {{(XLEN-1){1'b0}}, lt_u};
      ALU_XOR:  result = q_a ^ q_b;
      ALU_OR:   result = q_a | q_b;
      ALU_AND:  result = q_a & q_b;
      ALU_NONE: result = '0;
      // unused encodings from OP with bit 30 set
      default:  result = '0;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= pop;
    end
  end

  always_ff @(posedge clk) begin
    if (pop) begin
      out_result <= result;
      out_zero   <= (result == '0);
    end
  end

endmodule

// File: riscv_ex_top.sv
`timescale 1ns/1ps

module riscv_ex_top
  import riscv_ex_pkg::*;
#(
  parameter int QUEUE_DEPTH = 4,
  parameter int OUT_CREDITS = 2
) (
  input  logic             clk,
  input  logic             arst_n,
  input  logic             in_valid,
  input  logic [31:0]      in_inst,
  input  logic [XLEN-1:0]  in_a,
  input  logic [XLEN-1:0]  in_b,
  output logic             in_credit,
  output logic             out_valid,
  output logic [XLEN-1:0]  out_result,
  output logic             out_zero,
  input  logic             out_credit
);

  logic             push;
  alu_op_e          push_op;
  logic [XLEN-1:0]  push_a;
  logic [XLEN-1:0]  push_b;

  logic             q_valid;
  alu_op_e          q_op;
  logic [XLEN-1:0]  q_a;
  logic [XLEN-1:0]  q_b;

  riscv_ex_decode decode_i (
    .clk      (clk),
    .arst_n   (arst_n),
    .in_valid (in_valid),
    .in_inst  (in_inst),
    .in_a     (in_a),
    .in_b     (in_b),
    .push     (push),
    .push_op  (push_op),
    .push_a   (push_a),
    .push_b   (push_b)
  );

  // each pop frees a queue slot, so it returns upstream as a credit
  riscv_ex_queue #(
    .QUEUE_DEPTH (QUEUE_DEPTH)
  ) queue_i (
    .clk      (clk),
    .arst_n   (arst_n),
    .push     (push),
    .push_op  (push_op),
    .push_a   (push_a),
    .push_b   (push_b),
    .pop      (in_credit),
    .q_valid  (q_valid),
    .q_op     (q_op),
    .q_a      (q_a),
    .q_b      (q_b)
  );

  riscv_ex_alu #(
    .OUT_CREDITS (OUT_CREDITS)
  ) alu_i (
    .clk        (clk),
    .arst_n     (arst_n),
    .q_valid    (q_valid),
    .q_op       (q_op),
    .q_a        (q_a),
    .q_b        (q_b),
    .pop        (in_credit),
    .out_credit (out_credit),
    .out_valid  (out_valid),
    .out_result (out_result),
    .out_zero   (out_zero)
  );

endmodule

// File: tb_riscv_ex.sv
`timescale 1ns/1ps

module tb_riscv_ex
  import riscv_ex_pkg::*;
();

  localparam int QUEUE_DEPTH  = 4;
  localparam int OUT_CREDITS  = 2;
  localparam int NUM_VEC      = 43;
  localparam int NUM_TESTS    = 6;
  localparam int BP_TEST      = 6;
  localparam int RESET_CYCLES = 8;
  localparam int HOLD_CYCLES  = 30;

  logic             clk;
  logic             arst_n;
  logic             in_valid;
  logic [31:0]      in_inst;
  logic [XLEN-1:0]  in_a;
  logic [XLEN-1:0]  in_b;
  logic             in_credit;
  logic             out_valid;
  logic [XLEN-1:0]  out_result;
  logic             out_zero;
  logic             out_credit;

  // six words per vector: test, inst, a, b, result, zero
  logic [31:0] stim [NUM_VEC*6];

  // expected results in send order
  int               exp_test[$];
  logic [XLEN-1:0]  exp_result[$];
  logic             exp_zero[$];

  string test_name  [NUM_TESTS+1];
  int    test_total [NUM_TESTS+1];
  int    test_recv  [NUM_TESTS+1];
  int    test_err   [NUM_TESTS+1];

  int          next_vec = 0;
  int          sent_cnt = 0;
  int          recv_cnt = 0;
  int          credit_cnt = 0;
  int          returned_cnt = 0;
  int          err_cnt = 0;
  logic        hold = 1'b0;
  logic        starved = 1'b0;
  logic [31:0] drv_rng = 32'd69;
  logic [31:0] sink_rng = 32'd69;

  riscv_ex_top dut_i (
    .clk        (clk),
    .arst_n     (arst_n),
    .in_valid   (in_valid),
    .in_inst    (in_inst),
    .in_a       (in_a),
    .in_b       (in_b),
    .in_credit  (in_credit),
    .out_valid  (out_valid),
    .out_result (out_result),
    .out_zero   (out_zero),
    .out_credit (out_credit)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] field(input int idx, input int col);
    return stim[idx*6 + col];
  endfunction

  task automatic report_failure(input int test, input string what);
    $display("Error in %s: %s", test_name[test], what);
    err_cnt++;
    test_err[test]++;
  endtask

  task automatic check_result(input int test, input logic [XLEN-1:0] expected,
                              input logic [XLEN-1:0] actual);
    if (actual !== expected) begin
      $display("Mismatch in %s result: expected %h, actual %h",
               test_name[test], expected, actual);
      err_cnt++;
      test_err[test]++;
    end
  endtask

  task automatic check_zero(input int test, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("Mismatch in %s zero flag: expected %b, actual %b",
               test_name[test], expected, actual);
      err_cnt++;
      test_err[test]++;
    end
  endtask

  task automatic take_result();
    int test;
    if (exp_result.size() == 0) begin
      report_failure(0, "a result arrived with no instruction outstanding");
    end else begin
      test = exp_test.pop_front();
      check_result(test, exp_result.pop_front(), out_result);
      check_zero(test, exp_zero.pop_front(), out_zero);
      test_recv[test]++;
    end
    recv_cnt++;
  endtask

  // outputs are sampled mid-cycle, away from the edge
  initial begin
    forever begin
      @(negedge clk);
      if (arst_n) begin
        if (in_credit) begin
          credit_cnt++;
        end
        if (out_valid) begin
          take_result();
        end
      end
    end
  end

  // sink gives each credit back after 0 to 6 cycles
  initial begin
    int delay;
    out_credit = 1'b0;
    forever begin
      @(posedge clk);
      #1;
      out_credit = 1'b0;
      if (arst_n && !hold && recv_cnt > returned_cnt) begin
        sink_rng = xorshift(sink_rng);
        delay = int'(sink_rng % 7);
        repeat (delay) begin
          @(posedge clk);
          #1;
        end
        out_credit = 1'b1;
        returned_cnt++;
      end
    end
  end

  task automatic send_vector(input int idx);
    int gap;
    drv_rng = xorshift(drv_rng);
    gap = int'(drv_rng % 3);
    in_valid = 1'b0;
    repeat (gap) begin
      @(posedge clk);
      #1;
    end
    // no upstream credit left, so wait for a pop
    while (QUEUE_DEPTH + credit_cnt - sent_cnt == 0) begin
      starved = 1'b1;
      @(posedge clk);
      #1;
    end
    in_valid = 1'b1;
    in_inst  = field(idx, 1);
    in_a     = field(idx, 2);
    in_b     = field(idx, 3);
    exp_test.push_back(int'(field(idx, 0)));
    exp_result.push_back(field(idx, 4));
    exp_zero.push_back(field(idx, 5) != 32'd0);
    sent_cnt++;
    @(posedge clk);
    #1;
    in_valid = 1'b0;
  endtask

  task automatic send_group(input int test);
    while (next_vec < NUM_VEC && field(next_vec, 0) == 32'(test)) begin
      send_vector(next_vec);
      next_vec++;
    end
  endtask

  task automatic wait_drained();
    while (recv_cnt < sent_cnt || returned_cnt < recv_cnt) begin
      @(posedge clk);
      #1;
    end
    @(posedge clk);
    #1;
  endtask

  task automatic run_backpressure();
    int recv_before;
    starved = 1'b0;
    recv_before = recv_cnt;
    hold = 1'b1;
    fork
      begin
        repeat (HOLD_CYCLES) @(posedge clk);
        if (recv_cnt - recv_before > OUT_CREDITS) begin
          report_failure(BP_TEST, "more results left than the sink had credits for");
        end
        if (!starved) begin
          report_failure(BP_TEST, "upstream never ran out of credits during the stall");
        end
        hold = 1'b0;
      end
      send_group(BP_TEST);
    join
  endtask

  initial begin
    int pass_tests;
    int fail_tests;
    pass_tests = 0;
    fail_tests = 0;
    arst_n   = 1'b0;
    in_valid = 1'b0;
    in_inst  = '0;
    in_a     = '0;
    in_b     = '0;
    test_name[0] = "no_test";
    test_name[1] = "arith";
    test_name[2] = "logic_shift";
    test_name[3] = "compare";
    test_name[4] = "branch_zero";
    test_name[5] = "non_alu";
    test_name[6] = "backpressure";

    $readmemh("ex_stimulus.txt", stim);
    if (field(NUM_VEC - 1, 0) != 32'(BP_TEST)) begin
      report_failure(0, "stimulus file is incomplete or out of order");
    end
    for (int i = 0; i < NUM_VEC; i++) begin
      if (field(i, 0) >= 32'd1 && field(i, 0) <= 32'(NUM_TESTS)) begin
        test_total[int'(field(i, 0))]++;
      end else begin
        report_failure(0, "stimulus line holds an unknown test number");
      end
    end

    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    arst_n = 1'b1;

    for (int t = 1; t <= NUM_TESTS; t++) begin
      if (t == BP_TEST) begin
        run_backpressure();
      end else begin
        send_group(t);
      end
      wait_drained();
      if (credit_cnt != sent_cnt) begin
        report_failure(t, "upstream credit pulses differ from instructions sent");
      end
      if (test_err[t] == 0 && test_recv[t] == test_total[t]) begin
        pass_tests++;
        $display("test %0d %s: ok, %0d results", t, test_name[t], test_recv[t]);
      end else begin
        fail_tests++;
        $display("test %0d %s: failed, %0d errors, %0d of %0d results", t,
                 test_name[t], test_err[t], test_recv[t], test_total[t]);
      end
    end

    $display("%0d tests passed, %0d tests failed, %0d errors", pass_tests, fail_tests,
             err_cnt);
    if (err_cnt == 0 && fail_tests == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

  // run length bound from the vector count plus reset and stall time
  initial begin
    repeat (NUM_VEC*40 + RESET_CYCLES + HOLD_CYCLES) @(posedge clk);
    $display("Timeout: the run hung with %0d of %0d results received", recv_cnt, sent_cnt);
    $display(">>> FAIL");
    $finish;
  end

endmodule

// File: ex_stimulus.txt
// test inst a b result zero, all in hex
// test 6 runs while the sink holds its credits back
1 003100B3 00000005 00000007 0000000C 0
1 003100B3 7FFFFFFF 00000001 80000000 0
1 003100B3 FFFFFFFF 00000001 00000000 1
1 403100B3 00000010 00000003 0000000D 0
1 403100B3 00000000 00000001 FFFFFFFF 0
1 7FF10093 00001000 000007FF 000017FF 0
1 FFF10093 00000005 FFFFFFFF 00000004 0
1 003100B3 80000000 80000000 00000000 1
2 003140B3 0F0F00FF 00FF0F0F 0FF00FF0 0
2 003160B3 0F0F0000 000000F0 0F0F00F0 0
2 003170B3 FFFF0000 0F0F0F0F 0F0F0000 0
2 003170B3 F0F0F0F0 0F0F0F0F 00000000 1
2 003110B3 00000001 0000001F 80000000 0
2 003110B3 00000003 00000024 00000030 0
2 003150B3 80000000 00000004 08000000 0
2 403150B3 80000000 00000004 F8000000 0
2 403150B3 7FFFFFF0 00000024 07FFFFFF 0
2 40415093 F0000000 00000004 FF000000 0
2 003150B3 FFFFFFFF 00000021 7FFFFFFF 0
3 003120B3 FFFFFFFF 00000001 00000001 0
3 003130B3 FFFFFFFF 00000001 00000000 1
3 003120B3 00000001 80000000 00000000 1
3 003130B3 00000001 80000000 00000001 0
3 003120B3 00000005 00000005 00000000 1
4 00310063 12345678 12345678 00000000 1
4 00311063 00000010 00000011 FFFFFFFF 0
4 00314063 80000000 00000001 7FFFFFFF 0
4 40310063 DEADBEEF DEADBEEF 00000000 1
5 123450B7 00000011 12345000 00000000 1
5 00012083 00001000 00000008 00000000 1
5 00312023 00002000 00000004 00000000 1
5 000000EF 00000100 00000004 00000000 1
5 00000073 FFFFFFFF FFFFFFFF 00000000 1
6 003100B3 00000001 00000100 00000101 0
6 403100B3 00000202 00000100 00000102 0
6 003140B3 00000103 00000000 00000103 0
6 003160B3 00000100 00000004 00000104 0
6 003100B3 00000005 00000100 00000105 0
6 403100B3 00000206 00000100 00000106 0
6 003100B3 00000007 00000100 00000107 0
6 003160B3 00000100 00000008 00000108 0
6 003140B3 00000109 00000000 00000109 0
6 003100B3 0000000A 00000100 0000010A 0

// File: project.f
riscv_ex_pkg.sv
riscv_ex_decode.sv
riscv_ex_queue.sv
riscv_ex_alu.sv
riscv_ex_top.sv
tb_riscv_ex.sv

// File: Makefile
# Verilator build and run for the execute-stage testbench
# any variable below can be set on the make command line

VERILATOR ?= verilator
TOP       ?= tb_riscv_ex
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary -j 0
PASS_TEXT ?= >>> PASS

.PHONY: sim clean

# build, run, and fail unless the pass line shows up in the output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | awk -v pat='$(PASS_TEXT)' \
		'{ print } $$0 == pat { ok = 1 } END { exit !ok }'

clean:
	rm -rf $(BUILD_DIR)
